// ==== fetch_consts.svh ====
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// Data and address width
`define XLEN 32

// Instruction ROM depth in words
`define IMEM_WORDS 64

// BHT indexed by pc[7:2]
`define BHT_ENTRIES 64

// BTB indexed by pc[5:2], tag is pc[31:6]
`define BTB_ENTRIES 16

// First fetch address
`define RESET_PC 32'h0000_0000

`endif

// ==== fetch_pkg.sv ====
`include "fetch_consts.svh"

package fetch_pkg;

    // Opcodes seen by pre-decode
    typedef enum logic [6:0] {
        OP_OTHER  = 7'b0000000,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } op_t;

    typedef enum logic [1:0] {
        IDLE,
        REQ_HIGH,
        WAIT_ACK_LOW
    } issue_state_t;

    // Fetched packet handed to the decoder
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] inst;
        logic             pred_taken;
        logic [`XLEN-1:0] pred_target;
    } fetch_pkt_t;

    // Branch outcome from execute
    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        logic             taken;
        logic [`XLEN-1:0] target;
        logic             redirect;
        logic [`XLEN-1:0] redirect_pc;
    } resolve_t;

endpackage

// ==== inst_mem.sv ====
`timescale 1ns/1ps
`include "fetch_consts.svh"

module inst_mem (
    input  logic [`XLEN-1:0] addr,
    output logic [`XLEN-1:0] inst
);

    localparam int AW = $clog2(`IMEM_WORDS);

    logic [`XLEN-1:0] rom [`IMEM_WORDS];
    logic [AW-1:0]    word_idx;

    initial begin
        $readmemh("program.hex", rom);
    end

    // Word addressed, byte offset ignored
    assign word_idx = addr[AW+1:2];
    assign inst     = rom[word_idx];

endmodule

// ==== branch_history_table.sv ====
`timescale 1ns/1ps
`include "fetch_consts.svh"

module branch_history_table (
    input  logic                clk,
    input  logic                reset,
    input  logic [`XLEN-1:0]    lookup_pc,
    output logic [1:0]          counter,
    input  fetch_pkg::resolve_t resolve
);

    localparam int IDX_W = $clog2(`BHT_ENTRIES);

    logic [1:0]       ctr [`BHT_ENTRIES];
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    assign rd_idx  = lookup_pc[IDX_W+1:2];
    assign wr_idx  = resolve.pc[IDX_W+1:2];
    assign counter = ctr[rd_idx];

    // Saturating 2-bit counters, weakly not taken out of reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `BHT_ENTRIES; i++) begin
                ctr[i] <= 2'b01;
            end
        end else if (resolve.valid) begin
            if (resolve.taken && ctr[wr_idx] != 2'b11) begin
                ctr[wr_idx] <= ctr[wr_idx] + 2'd1;
            end else if (!resolve.taken && ctr[wr_idx] != 2'b00) begin
                ctr[wr_idx] <= ctr[wr_idx] - 2'd1;
            end
        end
    end

    // Execute must send a known branch address
    a_resolve_pc_known: assert property (
        @(posedge clk) disable iff (reset)
        resolve.valid |-> !$isunknown(resolve.pc)
    );

endmodule

// ==== branch_target_buffer.sv ====
`timescale 1ns/1ps
`include "fetch_consts.svh"

module branch_target_buffer (
    input  logic                clk,
    input  logic                reset,
    input  logic [`XLEN-1:0]    lookup_pc,
    output logic                hit,
    output logic [`XLEN-1:0]    target,
    input  fetch_pkg::resolve_t resolve
);

    localparam int IDX_W = $clog2(`BTB_ENTRIES);
    localparam int TAG_W = `XLEN - IDX_W - 2;

    logic [`BTB_ENTRIES-1:0] valid_q;
    logic [TAG_W-1:0]        tag_mem    [`BTB_ENTRIES];
    logic [`XLEN-1:0]        target_mem [`BTB_ENTRIES];

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] rd_tag;
    logic             fill;

    assign rd_idx = lookup_pc[IDX_W+1:2];
    assign rd_tag = lookup_pc[`XLEN-1:IDX_W+2];
    assign wr_idx = resolve.pc[IDX_W+1:2];
    assign fill   = resolve.valid && resolve.taken;

    assign hit    = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);
    assign target = target_mem[rd_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (fill) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Direct mapped, a conflicting fill simply replaces the old entry
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_mem[wr_idx]    <= resolve.pc[`XLEN-1:IDX_W+2];
            target_mem[wr_idx] <= resolve.target;
        end
    end

endmodule

// ==== fetch_stage.sv ====
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  fetch_pkg::resolve_t   resolve,
    output fetch_pkg::fetch_pkt_t pkt,
    output logic                  pkt_valid,
    input  logic                  pkt_ready
);

    import fetch_pkg::*;

    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] pc_next;
    logic [`XLEN-1:0] pc_plus4;
    logic [`XLEN-1:0] inst;
    logic [`XLEN-1:0] btb_target;
    logic [`XLEN-1:0] pred_target;
    logic [1:0]       counter;
    logic             btb_hit;
    logic             pred_taken;
    logic             advance;
    op_t              op;

    inst_mem u_imem (
        .addr (pc_q),
        .inst (inst)
    );

    branch_history_table u_bht (
        .clk       (clk),
        .reset     (reset),
        .lookup_pc (pc_q),
        .counter   (counter),
        .resolve   (resolve)
    );

    branch_target_buffer u_btb (
        .clk       (clk),
        .reset     (reset),
        .lookup_pc (pc_q),
        .hit       (btb_hit),
        .target    (btb_target),
        .resolve   (resolve)
    );

    // Pre-decode
    always_comb begin
        case (inst[6:0])
            OP_BRANCH: op = OP_BRANCH;
            OP_JAL:    op = OP_JAL;
            default:   op = OP_OTHER;
        endcase
    end

    // Taken needs a control op, a BTB hit and counter >= 2
    assign pc_plus4    = pc_q + `XLEN'd4;
    assign pred_taken  = (op != OP_OTHER) && btb_hit && counter[1];
    assign pred_target = pred_taken ? btb_target : pc_plus4;

    // Fetch never bubbles
    assign pkt_valid = 1'b1;
    assign advance   = pkt_valid && pkt_ready;

    assign pkt = '{pc: pc_q, inst: inst, pred_taken: pred_taken, pred_target: pred_target};

    always_comb begin
        if (resolve.valid && resolve.redirect) begin
            pc_next = resolve.redirect_pc;
        end else if (advance) begin
            pc_next = pred_target;
        end else begin
            pc_next = pc_q;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= `RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

endmodule

// ==== issue_stage.sv ====
`timescale 1ns/1ps

module issue_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  fetch_pkg::fetch_pkt_t pkt,
    output logic                  pkt_ready,
    output fetch_pkg::fetch_pkt_t out_pkt,
    output logic                  req,
    input  logic                  ack
);

    import fetch_pkg::*;

    issue_state_t state_q;
    fetch_pkt_t   pkt_q;

    assign pkt_ready = (state_q == IDLE);
    assign req       = (state_q == REQ_HIGH);
    assign out_pkt   = pkt_q;

    // Four-phase sequence, one packet in flight
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE:         state_q <= REQ_HIGH;
                REQ_HIGH:     if (ack) state_q <= WAIT_ACK_LOW;
                WAIT_ACK_LOW: if (!ack) state_q <= IDLE;
                default:      state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE) begin
            pkt_q <= pkt;
        end
    end

    a_req_held_until_ack: assert property (
        @(posedge clk) disable iff (reset)
        req && !ack |=> req
    );

    // Held from req rise until ack falls
    a_pkt_stable: assert property (
        @(posedge clk) disable iff (reset)
        (req || ack) |=> $stable(out_pkt)
    );

    a_no_ack_in_idle: assert property (
        @(posedge clk) disable iff (reset)
        state_q == IDLE |-> !ack
    );

endmodule

// ==== fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top (
    input  logic                  clk,
    input  logic                  reset,
    input  fetch_pkg::resolve_t   resolve,
    output fetch_pkg::fetch_pkt_t out_pkt,
    output logic                  req,
    input  logic                  ack
);

    import fetch_pkg::*;

    fetch_pkt_t pkt;
    logic       pkt_ready;

    // Fetch is always valid, so issue only looks at its own state
    fetch_stage u_fetch (
        .clk       (clk),
        .reset     (reset),
        .resolve   (resolve),
        .pkt       (pkt),
        .pkt_valid (),
        .pkt_ready (pkt_ready)
    );

    issue_stage u_issue (
        .clk       (clk),
        .reset     (reset),
        .pkt       (pkt),
        .pkt_ready (pkt_ready),
        .out_pkt   (out_pkt),
        .req       (req),
        .ack       (ack)
    );

endmodule

// ==== tb_fetch.sv ====
`timescale 1ns/1ps
`include "fetch_consts.svh"

module tb_fetch;

    import fetch_pkg::*;

    // About 56 packets at up to 16 cycles each, with margin
    localparam int MAX_CYCLES = 2000;
    localparam int RAND_PKTS  = 40;

    logic       clk;
    logic       reset;
    resolve_t   resolve;
    fetch_pkt_t out_pkt;
    logic       req;
    logic       ack;

    // Reference predictor state
    logic [`XLEN-1:0] rom_m   [`IMEM_WORDS];
    logic [1:0]       bht_m   [`BHT_ENTRIES];
    logic             btb_vld [`BTB_ENTRIES];
    logic [`XLEN-1:6] btb_tag [`BTB_ENTRIES];
    logic [`XLEN-1:0] btb_tgt [`BTB_ENTRIES];
    logic [`XLEN-1:0] exp_pc;
    fetch_pkt_t       last_pkt;
    int               cycles = 0;

    fetch_top u_dut (
        .clk     (clk),
        .reset   (reset),
        .resolve (resolve),
        .out_pkt (out_pkt),
        .req     (req),
        .ack     (ack)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the handshake made no progress within %0d cycles", MAX_CYCLES);
            $display("** FAIL **");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] want);
        if (got !== want) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, want);
            $display("** FAIL **");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Expected packet for a pc, from the prediction rule
    function automatic fetch_pkt_t expect_pkt(input logic [31:0] pc);
        fetch_pkt_t p;
        logic [6:0] opc;
        logic       hit;
        p.pc  = pc;
        p.inst = rom_m[pc[7:2]];
        opc = p.inst[6:0];
        hit = btb_vld[pc[5:2]] && (btb_tag[pc[5:2]] == pc[31:6]);
        // 0x63 branch, 0x6f jal
        p.pred_taken = ((opc == 7'h63) || (opc == 7'h6f)) && hit && (bht_m[pc[7:2]] >= 2'd2);
        p.pred_target = p.pred_taken ? btb_tgt[pc[5:2]] : pc + 32'd4;
        return p;
    endfunction

    task automatic update_tables(input logic [31:0] pc, input logic taken,
                                 input logic [31:0] target);
        if (taken && bht_m[pc[7:2]] != 2'd3) begin
            bht_m[pc[7:2]] = bht_m[pc[7:2]] + 2'd1;
        end else if (!taken && bht_m[pc[7:2]] != 2'd0) begin
            bht_m[pc[7:2]] = bht_m[pc[7:2]] - 2'd1;
        end
        if (taken) begin
            btb_vld[pc[5:2]] = 1'b1;
            btb_tag[pc[5:2]] = pc[31:6];
            btb_tgt[pc[5:2]] = target;
        end
    endtask

    // One four-phase transfer, optionally resolving the packet while ack is high
    task automatic receive_pkt(input bit send_res, input logic taken,
                               input logic [31:0] target);
        fetch_pkt_t  want;
        int unsigned delay;
        int unsigned hold;
        logic        redirect;
        logic [31:0] redirect_pc;
        while (!req) begin
            step();
        end
        want = expect_pkt(exp_pc);
        check_val("out_pkt.pc", out_pkt.pc, want.pc);
        check_val("out_pkt.inst", out_pkt.inst, want.inst);
        check_val("out_pkt.pred_taken", 32'(out_pkt.pred_taken), 32'(want.pred_taken));
        check_val("out_pkt.pred_target", out_pkt.pred_target, want.pred_target);
        last_pkt = out_pkt;
        delay = $urandom_range(8, 0);
        repeat (delay) begin
            step();
            check_val("req", 32'(req), 32'd1);
        end
        ack = 1'b1;
        step();
        check_val("req", 32'(req), 32'd0);
        if (send_res) begin
            redirect    = (taken != want.pred_taken) || (taken && target != want.pred_target);
            redirect_pc = taken ? target : want.pc + 32'd4;
            resolve = '{valid: 1'b1, pc: want.pc, taken: taken, target: target,
                        redirect: redirect, redirect_pc: redirect_pc};
            step();
            resolve = '0;
            update_tables(want.pc, taken, target);
            exp_pc = redirect ? redirect_pc : want.pred_target;
        end else begin
            exp_pc = want.pred_target;
        end
        hold = $urandom_range(3, 0);
        repeat (hold) begin
            step();
            check_val("out_pkt.pc", out_pkt.pc, want.pc);
        end
        ack = 1'b0;
    endtask

    task automatic straight_line_run();
        repeat (4) begin
            receive_pkt(1'b0, 1'b0, 32'h0);
            check_val("out_pkt.pred_taken", 32'(last_pkt.pred_taken), 32'd0);
        end
    endtask

    task automatic loop_training();
        // First pass mispredicts, second pass hits
        receive_pkt(1'b1, 1'b1, 32'h08);
        repeat (2) receive_pkt(1'b0, 1'b0, 32'h0);
        receive_pkt(1'b1, 1'b1, 32'h08);
        check_val("out_pkt.pc", last_pkt.pc, 32'h10);
        check_val("out_pkt.pred_taken", 32'(last_pkt.pred_taken), 32'd1);
        check_val("out_pkt.pred_target", last_pkt.pred_target, 32'h08);
        receive_pkt(1'b0, 1'b0, 32'h0);
        check_val("out_pkt.pc", last_pkt.pc, 32'h08);
    endtask

    task automatic not_taken_redirect();
        receive_pkt(1'b0, 1'b0, 32'h0);
        receive_pkt(1'b1, 1'b0, 32'h0);
        check_val("out_pkt.pred_taken", 32'(last_pkt.pred_taken), 32'd1);
        // Forward branch to the JAL
        receive_pkt(1'b1, 1'b1, 32'h50);
        check_val("out_pkt.pc", last_pkt.pc, 32'h14);
    endtask

    task automatic jal_eviction();
        receive_pkt(1'b1, 1'b1, 32'h08);
        check_val("out_pkt.pc", last_pkt.pc, 32'h50);
        check_val("out_pkt.pred_taken", 32'(last_pkt.pred_taken), 32'd0);
        repeat (2) receive_pkt(1'b0, 1'b0, 32'h0);
        receive_pkt(1'b1, 1'b0, 32'h0);
        check_val("out_pkt.pc", last_pkt.pc, 32'h10);
        check_val("out_pkt.pred_taken", 32'(last_pkt.pred_taken), 32'd0);
    endtask

    task automatic random_ack_delays();
        repeat (RAND_PKTS) receive_pkt(1'b0, 1'b0, 32'h0);
    endtask

    initial begin
        void'($urandom(87150));
        clk     = 1'b0;
        reset   = 1'b1;
        ack     = 1'b0;
        resolve = '0;
        exp_pc  = `RESET_PC;
        $readmemh("program.hex", rom_m);
        for (int i = 0; i < `BHT_ENTRIES; i++) begin
            bht_m[i] = 2'd1;
        end
        for (int i = 0; i < `BTB_ENTRIES; i++) begin
            btb_vld[i] = 1'b0;
        end
        repeat (10) @(posedge clk);
        #1;
        check_val("req", 32'(req), 32'd0);
        reset = 1'b0;
        straight_line_run();
        loop_training();
        not_taken_redirect();
        jal_eviction();
        random_ack_delays();
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== program.hex ====
// One 32-bit instruction word per line, in word address order
// An @ line sets the next word address, which is byte pc / 4
00000093
00300113
00108093 // loop head at 0x08
00000013
fe209ce3 // bne x1,x2 back to 0x08
02000e63 // beq x0,x0 forward to 0x50
00000013
00500193
@14
fb9ff06f // jal x0 to 0x08, BTB index 4 like 0x10
00000013
00000013

// ==== fetch_frontend.f ====
+incdir+.
fetch_pkg.sv
inst_mem.sv
branch_history_table.sv
branch_target_buffer.sv
fetch_stage.sv
issue_stage.sv
fetch_top.sv
tb_fetch.sv

// ==== Makefile ====
TOP = tb_fetch

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps --top-module fetch_top -f fetch_frontend.f
	verilator --lint-only --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f fetch_frontend.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f fetch_frontend.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
